// ==== aes_hwpe.f ====
+incdir+tb
hw/aes_hwpe_pkg.sv
hw/aes_regfile.sv
hw/aes_ctrl_fsm.sv
hw/aes_stream_source.sv
hw/aes_round_engine.sv
hw/aes_stream_sink.sv
hw/aes_hwpe_top.sv
tb/aes_hwpe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= aes_hwpe_tb
FILELIST  ?= aes_hwpe.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/aes_ref_model.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// Column c is block word c, row r is byte r of that word
function automatic logic [7:0] state_byte(input logic [BLOCK_W-1:0] s, input int row,
                                          input int col);
  return s[32*col + 8*row +: 8];
endfunction

// Shift-and-add multiply in GF(2^8) modulo 0x11B
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] x;
  p = 8'h00;
  x = a;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      p = p ^ x;
    end
    x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Circulant matrix, row 0 is 02 03 01 01
function automatic logic [7:0] mix_coef(input int row, input int k);
  case ((k - row + 4) % 4)
    0:       return 8'h02;
    1:       return 8'h03;
    default: return 8'h01;
  endcase
endfunction

function automatic logic [BLOCK_W-1:0] shift_rows(input logic [BLOCK_W-1:0] s);
  logic [BLOCK_W-1:0] o;
  for (int c = 0; c < 4; c++) begin
    for (int r = 0; r < 4; r++) begin
      o[32*c + 8*r +: 8] = state_byte(s, r, (c + r) % 4);
    end
  end
  return o;
endfunction

function automatic logic [BLOCK_W-1:0] mix_columns(input logic [BLOCK_W-1:0] s);
  logic [BLOCK_W-1:0] o;
  logic [7:0]         acc;
  for (int c = 0; c < 4; c++) begin
    for (int r = 0; r < 4; r++) begin
      acc = 8'h00;
      for (int k = 0; k < 4; k++) begin
        acc = acc ^ gf_mul(mix_coef(r, k), state_byte(s, k, c));
      end
      o[32*c + 8*r +: 8] = acc;
    end
  end
  return o;
endfunction

function automatic logic [BLOCK_W-1:0] add_round_key(input logic [BLOCK_W-1:0] s,
                                                     input logic [BLOCK_W-1:0] key);
  return s ^ key;
endfunction

// Same key in every round
function automatic logic [BLOCK_W-1:0] cipher_block(input logic [BLOCK_W-1:0] pt,
                                                    input logic [BLOCK_W-1:0] key,
                                                    input int rounds);
  logic [BLOCK_W-1:0] s;
  s = pt;
  for (int n = 0; n < rounds; n++) begin
    s = add_round_key(mix_columns(shift_rows(s)), key);
  end
  return s;
endfunction

`endif

// ==== tb/aes_hwpe_tb.sv ====
`timescale 1ns/1ps

module aes_hwpe_tb;

  import aes_hwpe_pkg::*;

  localparam int unsigned ROUNDS       = 4;
  localparam int          MEM_WORDS    = 256;
  localparam int          TIMEOUT      = 200;
  localparam int          QUIET_CYCLES = 40;

  logic                  clk;
  logic                  reset_n;
  logic                  cfg_valid;
  logic                  cfg_we;
  logic [CFG_ADDR_W-1:0] cfg_addr;
  logic [WORD_W-1:0]     cfg_wdata;
  logic [WORD_W-1:0]     cfg_rdata;
  logic                  cfg_rvalid;
  logic                  mem_rd_req;
  logic [WORD_W-1:0]     mem_rd_addr;
  logic [WORD_W-1:0]     mem_rd_data = '0;
  logic                  mem_wr_req;
  logic [WORD_W-1:0]     mem_wr_addr;
  logic [WORD_W-1:0]     mem_wr_data;
  logic                  done;

  // Memory model, plus a load port used by the test sequence
  logic [WORD_W-1:0] mem [MEM_WORDS];
  int                wr_count [MEM_WORDS];
  int                total_writes;
  int                done_count;
  logic              load_we;
  logic [7:0]        load_idx;
  logic [WORD_W-1:0] load_data;
  logic              count_clr;

  integer seed;
  int     errors;
  int     errors_at_start;
  int     tests_passed;
  int     tests_failed;

  `include "aes_ref_model.svh"

  aes_hwpe_top #(
    .ROUNDS (ROUNDS)
  ) u_aes_hwpe_top (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_valid_i   (cfg_valid),
    .cfg_we_i      (cfg_we),
    .cfg_addr_i    (cfg_addr),
    .cfg_wdata_i   (cfg_wdata),
    .cfg_rdata_o   (cfg_rdata),
    .cfg_rvalid_o  (cfg_rvalid),
    .mem_rd_req_o  (mem_rd_req),
    .mem_rd_addr_o (mem_rd_addr),
    .mem_rd_data_i (mem_rd_data),
    .mem_wr_req_o  (mem_wr_req),
    .mem_wr_addr_o (mem_wr_addr),
    .mem_wr_data_o (mem_wr_data),
    .done_o        (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Every address bit shows up in the word
  function automatic logic [WORD_W-1:0] fill_word(input logic [7:0] a);
    return {a ^ 8'h3c, ~a, {a[3:0], a[7:4]}, a ^ 8'hc5};
  endfunction

  // Reads answer one cycle later, DUT writes are counted per word
  always @(posedge clk) begin
    if (!reset_n) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i[7:0]]      <= fill_word(i[7:0]);
        wr_count[i[7:0]] <= 0;
      end
      total_writes <= 0;
      done_count   <= 0;
    end else begin
      if (mem_rd_req) begin
        mem_rd_data <= mem[mem_rd_addr[9:2]];
      end
      if (load_we) begin
        mem[load_idx] <= load_data;
      end
      if (count_clr) begin
        for (int i = 0; i < MEM_WORDS; i++) begin
          wr_count[i[7:0]] <= 0;
        end
        total_writes <= 0;
        done_count   <= 0;
      end else begin
        if (mem_wr_req) begin
          mem[mem_wr_addr[9:2]]      <= mem_wr_data;
          wr_count[mem_wr_addr[9:2]] <= wr_count[mem_wr_addr[9:2]] + 1;
          total_writes               <= total_writes + 1;
        end
        if (done) begin
          done_count <= done_count + 1;
        end
      end
    end
  end

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
    $display("Something failed");
    $finish;
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input int num, input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("Test %0d (%s) passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s) failed with %0d errors", num, name, errors - errors_at_start);
    end
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_valid <= 1'b0;
    cfg_we    <= 1'b0;
  endtask

  task automatic cfg_read(input logic [CFG_ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
    int waited;
    @(posedge clk);
    cfg_valid <= 1'b1;
    cfg_we    <= 1'b0;
    cfg_addr  <= addr;
    @(posedge clk);
    cfg_valid <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_timeout("cfg_rvalid_o");
      end
    end while (!cfg_rvalid);
    assert (waited == 1)
      else report_fail($sformatf("cfg_rvalid_o came %0d cycles after the strobe", waited));
    data = cfg_rdata;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_timeout("done_o");
      end
    end while (!done);
  endtask

  task automatic wait_read_req();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_timeout("mem_rd_req_o");
      end
    end while (!mem_rd_req);
  endtask

  task automatic clear_counts();
    @(posedge clk);
    count_clr <= 1'b1;
    @(posedge clk);
    count_clr <= 1'b0;
  endtask

  task automatic load_block(input int idx, input logic [BLOCK_W-1:0] blk);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      @(posedge clk);
      load_we   <= 1'b1;
      load_idx  <= 8'(idx + i);
      load_data <= blk[32*i +: 32];
    end
    @(posedge clk);
    load_we <= 1'b0;
  endtask

  task automatic rand_block(output logic [BLOCK_W-1:0] blk);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      blk[32*i +: 32] = $random(seed);
    end
  endtask

  // Indices are word indices, the registers take byte addresses
  task automatic setup_job(input logic [BLOCK_W-1:0] key, input int src, input int dst,
                           input logic [BLOCK_W-1:0] pt);
    load_block(src, pt);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      cfg_write(CFG_ADDR_W'(i), key[32*i +: 32]);
    end
    cfg_write(REG_SRC_BASE, src * 4);
    cfg_write(REG_DST_BASE, dst * 4);
    clear_counts();
  endtask

  task automatic execute_job();
    logic [WORD_W-1:0] rd;
    cfg_write(REG_CMD, 32'h1);
    cfg_read(REG_STATUS, rd);
    assert (rd == 32'h1) else report_fail($sformatf("status %h while running", rd));
    wait_done();
    cfg_read(REG_STATUS, rd);
    assert (rd == 32'h2) else report_fail($sformatf("status %h after done", rd));
  endtask

  task automatic check_result(input logic [BLOCK_W-1:0] key, input logic [BLOCK_W-1:0] pt,
                              input int dst);
    logic [BLOCK_W-1:0] exp;
    logic [7:0]         idx;
    int                 stray;
    exp   = cipher_block(pt, key, ROUNDS);
    stray = 0;
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      idx = 8'(dst + i);
      assert (mem[idx] == exp[32*i +: 32])
        else report_fail($sformatf("word %0d is %h, expected %h", idx, mem[idx],
                                   exp[32*i +: 32]));
      assert (wr_count[idx] == 1)
        else report_fail($sformatf("word %0d written %0d times", idx, wr_count[idx]));
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      if ((i < dst || i >= dst + 4) && wr_count[i[7:0]] != 0) begin
        stray++;
      end
    end
    assert (stray == 0) else report_fail($sformatf("%0d words outside the block written", stray));
  endtask

  task automatic run_job(input logic [BLOCK_W-1:0] key, input int src, input int dst,
                         input logic [BLOCK_W-1:0] pt);
    setup_job(key, src, dst, pt);
    execute_job();
    check_result(key, pt, dst);
  endtask

  initial begin
    logic [WORD_W-1:0]  rd;
    logic [BLOCK_W-1:0] key;
    logic [BLOCK_W-1:0] pt;
    logic [WORD_W-1:0]  src_base;
    logic [WORD_W-1:0]  dst_base;
    int                 sb;
    int                 db;

    seed         = 32'h120d_ed99;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    reset_n      = 1'b0;
    cfg_valid    = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    load_we      = 1'b0;
    load_idx     = '0;
    load_data    = '0;
    count_clr    = 1'b0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    begin_test();
    cfg_read(REG_STATUS, rd);
    assert (rd == '0) else report_fail($sformatf("status %h after reset", rd));
    repeat (20) @(posedge clk);
    assert (total_writes == 0) else report_fail("memory written while idle");
    assert (done_count == 0) else report_fail("done_o pulsed while idle");
    end_test(1, "reset state");

    begin_test();
    rand_block(key);
    src_base = $random(seed);
    dst_base = $random(seed);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      cfg_write(CFG_ADDR_W'(i), key[32*i +: 32]);
    end
    cfg_write(REG_SRC_BASE, src_base);
    cfg_write(REG_DST_BASE, dst_base);
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      cfg_read(CFG_ADDR_W'(i), rd);
      assert (rd == key[32*i +: 32])
        else report_fail($sformatf("key word %0d read %h", i, rd));
    end
    cfg_read(REG_SRC_BASE, rd);
    assert (rd == src_base) else report_fail($sformatf("source base read %h", rd));
    cfg_read(REG_DST_BASE, rd);
    assert (rd == dst_base) else report_fail($sformatf("destination base read %h", rd));
    end_test(2, "register readback");

    begin_test();
    rand_block(key);
    rand_block(pt);
    run_job(key, 8, 40, pt);
    end_test(3, "single job");

    // Restart on the same setup, done must drop with the new start
    begin_test();
    clear_counts();
    execute_job();
    check_result(key, pt, 40);
    end_test(4, "status flags");

    begin_test();
    for (int n = 0; n < 8; n++) begin
      sb = {$random(seed)} % 64;
      db = (sb + 1 + ({$random(seed)} % 63)) % 64;
      rand_block(key);
      rand_block(pt);
      run_job(key, sb * 4, db * 4, pt);
    end
    end_test(5, "random jobs");

    begin_test();
    rand_block(key);
    rand_block(pt);
    setup_job(key, 16, 64, pt);
    cfg_write(REG_CMD, 32'h1);
    wait_read_req();
    cfg_write(REG_CMD, 32'h2);
    repeat (QUIET_CYCLES) @(posedge clk);
    assert (total_writes == 0)
      else report_fail($sformatf("%0d memory writes after clear", total_writes));
    assert (done_count == 0) else report_fail("done_o pulsed after clear");
    cfg_read(REG_STATUS, rd);
    assert (rd == '0) else report_fail($sformatf("status %h after clear", rd));
    rand_block(key);
    rand_block(pt);
    run_job(key, 20, 100, pt);
    end_test(6, "clear mid-job");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== hw/aes_hwpe_top.sv ====
`timescale 1ns/1ps

module aes_hwpe_top #(
  parameter int unsigned ROUNDS = 4
) (
  input  logic                                  clk,
  input  logic                                  reset_n,
  // Configuration port
  input  logic                                  cfg_valid_i,
  input  logic                                  cfg_we_i,
  input  logic [aes_hwpe_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]       cfg_wdata_i,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       cfg_rdata_o,
  output logic                                  cfg_rvalid_o,
  // Memory read port, one-cycle latency
  output logic                                  mem_rd_req_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       mem_rd_addr_o,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]       mem_rd_data_i,
  // Memory write port
  output logic                                  mem_wr_req_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       mem_wr_addr_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       mem_wr_data_o,
  output logic                                  done_o
);

  import aes_hwpe_pkg::*;

  logic [BLOCK_W-1:0] key;
  logic [WORD_W-1:0]  src_base;
  logic [WORD_W-1:0]  dst_base;
  logic               start;
  logic               clear;
  logic               busy;
  logic               done;
  logic               src_start;
  logic               eng_clear;
  logic [BLOCK_W-1:0] blk;
  logic               blk_valid;
  logic [BLOCK_W-1:0] res;
  logic               res_valid;
  logic               wr_done;

  aes_regfile u_aes_regfile (
    .clk          (clk),
    .reset_n      (reset_n),
    .cfg_valid_i  (cfg_valid_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .busy_i       (busy),
    .done_i       (done),
    .cfg_rdata_o  (cfg_rdata_o),
    .cfg_rvalid_o (cfg_rvalid_o),
    .key_o        (key),
    .src_base_o   (src_base),
    .dst_base_o   (dst_base),
    .start_o      (start),
    .clear_o      (clear)
  );

  aes_ctrl_fsm u_aes_ctrl_fsm (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (clear),
    .start_i     (start),
    .wr_done_i   (wr_done),
    .src_start_o (src_start),
    .eng_clear_o (eng_clear),
    .busy_o      (busy),
    .done_o      (done)
  );

  aes_stream_source u_aes_stream_source (
    .clk           (clk),
    .reset_n       (reset_n),
    .clear_i       (clear),
    .start_i       (src_start),
    .base_i        (src_base),
    .mem_rd_data_i (mem_rd_data_i),
    .mem_rd_req_o  (mem_rd_req_o),
    .mem_rd_addr_o (mem_rd_addr_o),
    .blk_o         (blk),
    .blk_valid_o   (blk_valid)
  );

  aes_round_engine #(
    .ROUNDS (ROUNDS)
  ) u_aes_round_engine (
    .clk         (clk),
    .reset_n     (reset_n),
    .clear_i     (eng_clear),
    .blk_i       (blk),
    .blk_valid_i (blk_valid),
    .key_i       (key),
    .res_o       (res),
    .res_valid_o (res_valid)
  );

  aes_stream_sink u_aes_stream_sink (
    .clk           (clk),
    .reset_n       (reset_n),
    .clear_i       (clear),
    .res_i         (res),
    .res_valid_i   (res_valid),
    .base_i        (dst_base),
    .mem_wr_req_o  (mem_wr_req_o),
    .mem_wr_addr_o (mem_wr_addr_o),
    .mem_wr_data_o (mem_wr_data_o),
    .wr_done_o     (wr_done)
  );

  assign done_o = done;

endmodule

// ==== hw/aes_stream_sink.sv ====
`timescale 1ns/1ps

module aes_stream_sink (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               clear_i,
  input  logic [aes_hwpe_pkg::BLOCK_W-1:0]   res_i,
  input  logic                               res_valid_i,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]    base_i,
  output logic                               mem_wr_req_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]    mem_wr_addr_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]    mem_wr_data_o,
  output logic                               wr_done_o
);

  import aes_hwpe_pkg::*;

  localparam int unsigned CNT_W = $clog2(BLOCK_WORDS);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(BLOCK_WORDS - 1);

  logic [BLOCK_W-1:0] res_q;
  logic               active_q;
  logic [CNT_W-1:0]   wr_cnt_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      active_q <= 1'b0;
      wr_cnt_q <= '0;
    end else if (clear_i) begin
      active_q <= 1'b0;
      wr_cnt_q <= '0;
    end else if (res_valid_i) begin
      active_q <= 1'b1;
      wr_cnt_q <= '0;
    end else if (active_q) begin
      wr_cnt_q <= wr_cnt_q + 1'b1;
      if (wr_cnt_q == LAST) begin
        active_q <= 1'b0;
      end
    end
  end

  // Result block held for the four writes
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      res_q <= res_i;
    end
  end

  assign mem_wr_req_o  = active_q;
  assign mem_wr_addr_o = base_i + WORD_W'({wr_cnt_q, 2'b00});
  assign mem_wr_data_o = res_q[wr_cnt_q*WORD_W +: WORD_W];
  assign wr_done_o     = active_q && (wr_cnt_q == LAST);

endmodule

// ==== hw/aes_round_engine.sv ====
`timescale 1ns/1ps

module aes_round_engine #(
  parameter int unsigned ROUNDS = 4
) (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               clear_i,
  input  logic [aes_hwpe_pkg::BLOCK_W-1:0]   blk_i,
  input  logic                               blk_valid_i,
  input  logic [aes_hwpe_pkg::BLOCK_W-1:0]   key_i,
  output logic [aes_hwpe_pkg::BLOCK_W-1:0]   res_o,
  output logic                               res_valid_o
);

  import aes_hwpe_pkg::*;

  localparam int unsigned CNT_W = $clog2(ROUNDS + 1);
  localparam logic [CNT_W-1:0] LAST_ROUND = CNT_W'(ROUNDS - 1);

  logic [BLOCK_W-1:0] state_q;
  logic [BLOCK_W-1:0] round_out;
  logic               run_q;
  logic [CNT_W-1:0]   round_cnt_q;
  logic               res_valid_q;

  // Multiply by x in GF(2^8) modulo 0x11B
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Row r of the state moves left by r columns
  function automatic logic [BLOCK_W-1:0] shift_rows(input logic [BLOCK_W-1:0] s);
    logic [BLOCK_W-1:0] o;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[32*c + 8*r +: 8] = s[32*((c + r) % 4) + 8*r +: 8];
      end
    end
    return o;
  endfunction

  function automatic logic [BLOCK_W-1:0] mix_columns(input logic [BLOCK_W-1:0] s);
    logic [BLOCK_W-1:0] o;
    logic [7:0]         a0, a1, a2, a3;
    for (int c = 0; c < 4; c++) begin
      a0 = s[32*c +:  8];
      a1 = s[32*c + 8 +:  8];
      a2 = s[32*c + 16 +: 8];
      a3 = s[32*c + 24 +: 8];
      // 3a is 2a xor a
      o[32*c +: 8]      = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
      o[32*c + 8 +: 8]  = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
      o[32*c + 16 +: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
      o[32*c + 24 +: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    end
    return o;
  endfunction

  // One reduced round with the same key every round
  assign round_out = mix_columns(shift_rows(state_q)) ^ key_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      run_q       <= 1'b0;
      round_cnt_q <= '0;
      res_valid_q <= 1'b0;
    end else if (clear_i) begin
      run_q       <= 1'b0;
      round_cnt_q <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= 1'b0;
      if (blk_valid_i) begin
        run_q       <= 1'b1;
        round_cnt_q <= '0;
      end else if (run_q) begin
        round_cnt_q <= round_cnt_q + 1'b1;
        if (round_cnt_q == LAST_ROUND) begin
          run_q       <= 1'b0;
          res_valid_q <= 1'b1;
        end
      end
    end
  end

  // Block state advances one round per cycle
  always_ff @(posedge clk) begin
    if (blk_valid_i) begin
      state_q <= blk_i;
    end else if (run_q) begin
      state_q <= round_out;
    end
  end

  assign res_o       = state_q;
  assign res_valid_o = res_valid_q;

endmodule

// ==== hw/aes_stream_source.sv ====
`timescale 1ns/1ps

module aes_stream_source (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               clear_i,
  input  logic                               start_i,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]    base_i,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]    mem_rd_data_i,
  output logic                               mem_rd_req_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]    mem_rd_addr_o,
  output logic [aes_hwpe_pkg::BLOCK_W-1:0]   blk_o,
  output logic                               blk_valid_o
);

  import aes_hwpe_pkg::*;

  localparam int unsigned CNT_W = $clog2(BLOCK_WORDS);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(BLOCK_WORDS - 1);

  logic             issue_q;
  logic [CNT_W-1:0] issue_cnt_q;
  logic             rvalid_q;
  logic [CNT_W-1:0] ridx_q;
  // Only the first three words are stored, the last is taken from the bus
  logic [WORD_W-1:0] word_q [BLOCK_WORDS-1];

  // Read issue, one word per cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      issue_q     <= 1'b0;
      issue_cnt_q <= '0;
    end else if (clear_i) begin
      issue_q     <= 1'b0;
      issue_cnt_q <= '0;
    end else if (start_i) begin
      issue_q     <= 1'b1;
      issue_cnt_q <= '0;
    end else if (issue_q) begin
      issue_cnt_q <= issue_cnt_q + 1'b1;
      if (issue_cnt_q == LAST) begin
        issue_q <= 1'b0;
      end
    end
  end

  // Returning data trails the request by one cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rvalid_q <= 1'b0;
      ridx_q   <= '0;
    end else begin
      rvalid_q <= issue_q && !clear_i;
      ridx_q   <= issue_cnt_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid_q && (ridx_q != LAST)) begin
      word_q[ridx_q] <= mem_rd_data_i;
    end
  end

  assign mem_rd_req_o  = issue_q;
  assign mem_rd_addr_o = base_i + WORD_W'({issue_cnt_q, 2'b00});

  assign blk_o       = {mem_rd_data_i, word_q[2], word_q[1], word_q[0]};
  assign blk_valid_o = rvalid_q && (ridx_q == LAST);

endmodule

// ==== hw/aes_ctrl_fsm.sv ====
`timescale 1ns/1ps

module aes_ctrl_fsm (
  input  logic clk,
  input  logic reset_n,
  input  logic clear_i,
  input  logic start_i,
  input  logic wr_done_i,
  output logic src_start_o,
  output logic eng_clear_o,
  output logic busy_o,
  output logic done_o
);

  import aes_hwpe_pkg::*;

  aes_state_t state_q;
  aes_state_t state_d;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= AES_IDLE;
    end else if (clear_i) begin
      state_q <= AES_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      AES_IDLE: begin
        // Start is only honoured from idle
        if (start_i) begin
          state_d = AES_STARTING;
        end
      end
      AES_STARTING: begin
        state_d = AES_WORKING;
      end
      AES_WORKING: begin
        // Last result word written
        if (wr_done_i) begin
          state_d = AES_FINISHED;
        end
      end
      AES_FINISHED: begin
        state_d = AES_IDLE;
      end
      default: begin
        state_d = AES_IDLE;
      end
    endcase
  end

  // Outputs decoded from the current state
  always_comb begin
    src_start_o = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      AES_STARTING: src_start_o = 1'b1;
      AES_FINISHED: done_o      = 1'b1;
      default: ;
    endcase
  end

  // Engine is held clear while idle and on an abort
  assign eng_clear_o = (state_q == AES_IDLE) || clear_i;
  assign busy_o      = (state_q != AES_IDLE);

endmodule

// ==== hw/aes_regfile.sv ====
`timescale 1ns/1ps

module aes_regfile (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  logic                                  cfg_valid_i,
  input  logic                                  cfg_we_i,
  input  logic [aes_hwpe_pkg::CFG_ADDR_W-1:0]   cfg_addr_i,
  input  logic [aes_hwpe_pkg::WORD_W-1:0]       cfg_wdata_i,
  input  logic                                  busy_i,
  input  logic                                  done_i,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       cfg_rdata_o,
  output logic                                  cfg_rvalid_o,
  output logic [aes_hwpe_pkg::BLOCK_W-1:0]      key_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       src_base_o,
  output logic [aes_hwpe_pkg::WORD_W-1:0]       dst_base_o,
  output logic                                  start_o,
  output logic                                  clear_o
);

  import aes_hwpe_pkg::*;

  logic [BLOCK_W-1:0] key_q;
  logic [WORD_W-1:0]  src_base_q;
  logic [WORD_W-1:0]  dst_base_q;
  logic               done_q;
  logic               cmd_wr;

  // Command writes become single-cycle strobes
  assign cmd_wr  = cfg_valid_i && cfg_we_i && (cfg_addr_i == REG_CMD);
  assign start_o = cmd_wr && cfg_wdata_i[CMD_START_BIT];
  assign clear_o = cmd_wr && cfg_wdata_i[CMD_CLEAR_BIT];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q      <= '0;
      src_base_q <= '0;
      dst_base_q <= '0;
    end else if (cfg_valid_i && cfg_we_i) begin
      case (cfg_addr_i)
        REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: begin
          key_q[cfg_addr_i[1:0]*WORD_W +: WORD_W] <= cfg_wdata_i;
        end
        REG_SRC_BASE: src_base_q <= cfg_wdata_i;
        REG_DST_BASE: dst_base_q <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // Sticky done where a finishing job wins over a late command
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end else if (start_o || clear_o) begin
      done_q <= 1'b0;
    end
  end

  // Read data returns one cycle after the strobe
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cfg_rdata_o  <= '0;
      cfg_rvalid_o <= 1'b0;
    end else begin
      cfg_rvalid_o <= cfg_valid_i && !cfg_we_i;
      if (cfg_valid_i && !cfg_we_i) begin
        case (cfg_addr_i)
          REG_KEY0, REG_KEY1, REG_KEY2, REG_KEY3: begin
            cfg_rdata_o <= key_q[cfg_addr_i[1:0]*WORD_W +: WORD_W];
          end
          REG_SRC_BASE: cfg_rdata_o <= src_base_q;
          REG_DST_BASE: cfg_rdata_o <= dst_base_q;
          REG_STATUS:   cfg_rdata_o <= {{(WORD_W-2){1'b0}}, done_q, busy_i};
          default:      cfg_rdata_o <= '0;
        endcase
      end
    end
  end

  assign key_o      = key_q;
  assign src_base_o = src_base_q;
  assign dst_base_o = dst_base_q;

endmodule

// ==== hw/aes_hwpe_pkg.sv ====
package aes_hwpe_pkg;

  // Memory word and cipher block geometry
  localparam int unsigned WORD_W      = 32;
  localparam int unsigned BLOCK_WORDS = 4;
  localparam int unsigned BLOCK_W     = WORD_W * BLOCK_WORDS;

  // Configuration space, one word per register
  localparam int unsigned CFG_ADDR_W = 3;

  // Key word 0 holds key bytes 0 to 3
  localparam logic [CFG_ADDR_W-1:0] REG_KEY0     = 3'd0;
  localparam logic [CFG_ADDR_W-1:0] REG_KEY1     = 3'd1;
  localparam logic [CFG_ADDR_W-1:0] REG_KEY2     = 3'd2;
  localparam logic [CFG_ADDR_W-1:0] REG_KEY3     = 3'd3;
  localparam logic [CFG_ADDR_W-1:0] REG_SRC_BASE = 3'd4;
  localparam logic [CFG_ADDR_W-1:0] REG_DST_BASE = 3'd5;
  // Bit 0 start, bit 1 clear
  localparam logic [CFG_ADDR_W-1:0] REG_CMD      = 3'd6;
  // Bit 0 busy, bit 1 done, read only
  localparam logic [CFG_ADDR_W-1:0] REG_STATUS   = 3'd7;

  localparam int unsigned CMD_START_BIT = 0;
  localparam int unsigned CMD_CLEAR_BIT = 1;

  // Controller states
  typedef enum logic [1:0] {
    AES_IDLE     = 2'd0,
    AES_STARTING = 2'd1,
    AES_WORKING  = 2'd2,
    AES_FINISHED = 2'd3
  } aes_state_t;

endpackage
